/* flist.f */
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_access.sv
rtl/csr_trap_regs.sv
rtl/csr_counters.sv
rtl/csr_top.sv
tests/csr_chk.sv
tests/csr_tb.sv

/* run.sh */
#!/bin/sh
# build and run the CSR testbench with Verilator

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module csr_tb -f flist.f -o csr_sim \
  && ./obj_dir/csr_sim > sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
cat sim.log
if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

/* tests/csr_tb.sv */
// CSR block testbench
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_tb;

  import csr_pkg::*;

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST + 100;
  localparam logic [`CSR_XLEN-1:0] IRQ_MASK = 32'h7FFF_0888;   // implemented mie bits

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     csr_access_i;
  csr_addr_e                csr_addr_i;
  csr_op_e                  csr_op_i;
  logic [`CSR_XLEN-1:0]     csr_wdata_i;
  logic                     instr_new_i;
  logic [`CSR_XLEN-1:0]     csr_rdata_o;
  logic                     illegal_csr_o;
  logic                     irq_software_i;
  logic                     irq_timer_i;
  logic                     irq_external_i;
  logic [`CSR_NUM_FAST-1:0] irq_fast_i;
  logic                     irq_pending_o;
  irq_vec_t                 mip_o;
  logic [`CSR_XLEN-1:0]     pc_if_i;
  logic [`CSR_XLEN-1:0]     pc_id_i;
  logic                     save_if_i;
  logic                     save_cause_i;
  logic                     restore_mret_i;
  logic [`CSR_CAUSE_W-1:0]  mcause_i;
  logic [`CSR_XLEN-1:0]     mtval_i;
  logic                     mstatus_mie_o;
  logic [`CSR_XLEN-1:0]     mepc_o;
  logic                     instr_ret_i;

  integer seed;
  int     errors = 0;
  int     checks = 0;

  csr_top u_csr_top (.*);

  always #10 clk_i = ~clk_i;

  // one edge, then back to the drive point
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // access held over one edge
  task automatic csr_cmd(input csr_op_e op, input csr_addr_e addr, input logic [31:0] data);
    csr_access_i = 1'b1;
    instr_new_i  = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = addr;
    csr_wdata_i  = data;
    step();
    csr_access_i = 1'b0;
    instr_new_i  = 1'b0;
    csr_op_i     = CSR_OP_READ;
  endtask

  // combinational read, sampled mid-cycle
  task automatic csr_peek(input csr_addr_e addr, output logic [31:0] data);
    csr_access_i = 1'b1;
    csr_op_i     = CSR_OP_READ;
    csr_addr_i   = addr;
    #5;
    data = csr_rdata_o;
    step();
    csr_access_i = 1'b0;
  endtask

  task automatic read_check(input csr_addr_e addr, input logic [31:0] exp);
    logic [31:0] val;
    csr_peek(addr, val);
    check_word($sformatf("csr_rdata_o[%s]", addr.name()), exp, val);
  endtask

  task automatic illegal_check(input logic [11:0] addr, input csr_op_e op);
    csr_access_i = 1'b1;
    instr_new_i  = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = csr_addr_e'(addr);
    csr_wdata_i  = $random(seed);
    #5;
    check_word("illegal_csr_o", 32'h1, {31'd0, illegal_csr_o});
    step();
    csr_access_i = 1'b0;
    instr_new_i  = 1'b0;
  endtask

  // write data per operation
  function automatic logic [31:0] op_result(input csr_op_e op, input logic [31:0] old,
                                            input logic [31:0] d);
    case (op)
      CSR_OP_WRITE: return d;
      CSR_OP_SET:   return old | d;
      CSR_OP_CLEAR: return old & ~d;
      default:      return old;
    endcase
  endfunction

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : main
    logic [31:0] rnd;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] exp_mscratch;
    logic [31:0] exp_mtval;
    logic [31:0] exp_mepc;
    logic [31:0] exp_mie;
    logic [31:0] exp_mip;
    csr_op_e     op;
    csr_addr_e   addr;
    int          k;
    int          pulses;

    seed           = 32'h6a161ce2;
    rst_ni         = 1'b0;
    csr_access_i   = 1'b0;
    csr_addr_i     = CSR_MSTATUS;
    csr_op_i       = CSR_OP_READ;
    csr_wdata_i    = '0;
    instr_new_i    = 1'b0;
    irq_software_i = 1'b0;
    irq_timer_i    = 1'b0;
    irq_external_i = 1'b0;
    irq_fast_i     = '0;
    pc_if_i        = '0;
    pc_id_i        = '0;
    save_if_i      = 1'b0;
    save_cause_i   = 1'b0;
    restore_mret_i = 1'b0;
    mcause_i       = '0;
    mtval_i        = '0;
    instr_ret_i    = 1'b0;
    exp_mscratch   = '0;
    exp_mtval      = '0;

    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_word("mepc_o", 32'h0, mepc_o);
    check_word("mstatus_mie_o", 32'h0, {31'd0, mstatus_mie_o});
    check_word("irq_pending_o", 32'h0, {31'd0, irq_pending_o});

    // 1: write, set and clear on mscratch and mtval
    for (int i = 0; i < 16; i++) begin
      rnd  = $random(seed);
      op   = (rnd[1:0] == 2'd0) ? CSR_OP_WRITE : csr_op_e'(rnd[1:0]);
      addr = rnd[2] ? CSR_MTVAL : CSR_MSCRATCH;
      rnd  = $random(seed);
      csr_cmd(op, addr, rnd);
      if (addr == CSR_MTVAL) begin
        exp_mtval = op_result(op, exp_mtval, rnd);
      end else begin
        exp_mscratch = op_result(op, exp_mscratch, rnd);
      end
      read_check(CSR_MSCRATCH, exp_mscratch);
      read_check(CSR_MTVAL, exp_mtval);
    end
    csr_cmd(CSR_OP_READ, CSR_MSCRATCH, $random(seed));   // read op, no change
    read_check(CSR_MSCRATCH, exp_mscratch);

    // 2: mepc and mcause masking
    rnd = $random(seed) | 32'h1;
    csr_cmd(CSR_OP_WRITE, CSR_MEPC, rnd);
    exp_mepc = {rnd[31:1], 1'b0};
    check_word("mepc_o", exp_mepc, mepc_o);
    read_check(CSR_MEPC, exp_mepc);
    rnd = $random(seed);
    csr_cmd(CSR_OP_WRITE, CSR_MCAUSE, rnd);
    read_check(CSR_MCAUSE, rnd & 32'h8000_001F);

    // 3: mip is lines masked by mie
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      csr_cmd(CSR_OP_WRITE, CSR_MIE, rnd);
      exp_mie = rnd & IRQ_MASK;
      read_check(CSR_MIE, exp_mie);
      rnd = (i == 0) ? 32'h0 : $random(seed);
      irq_software_i = rnd[0];
      irq_timer_i    = rnd[1];
      irq_external_i = rnd[2];
      irq_fast_i     = rnd[31:17];
      exp_mip = {1'b0, irq_fast_i, 4'b0, irq_external_i, 3'b0, irq_timer_i, 3'b0,
                 irq_software_i, 3'b0} & exp_mie;
      read_check(CSR_MIP, exp_mip);
      check_word("mip_o", {14'd0, exp_mip[3], exp_mip[7], exp_mip[11], exp_mip[30:16]},
                 {14'd0, mip_o});
      check_word("irq_pending_o", {31'd0, exp_mip != '0}, {31'd0, irq_pending_o});
    end

    // 4: trap save from IF, then mret
    csr_cmd(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0008);   // mie on, mpie off
    read_check(CSR_MSTATUS, 32'h0000_0008);
    check_word("mstatus_mie_o", 32'h1, {31'd0, mstatus_mie_o});
    rnd          = $random(seed);
    pc_if_i      = $random(seed);
    pc_id_i      = $random(seed);
    mtval_i      = $random(seed);
    mcause_i     = rnd[5:0];
    save_if_i    = 1'b1;
    save_cause_i = 1'b1;
    step();
    save_cause_i = 1'b0;
    save_if_i    = 1'b0;
    exp_mepc     = pc_if_i;
    exp_mtval    = mtval_i;
    check_word("mepc_o", exp_mepc, mepc_o);
    check_word("mstatus_mie_o", 32'h0, {31'd0, mstatus_mie_o});
    read_check(CSR_MCAUSE, {rnd[5], 26'd0, rnd[4:0]});
    read_check(CSR_MTVAL, exp_mtval);
    read_check(CSR_MSTATUS, 32'h0000_0080);
    restore_mret_i = 1'b1;
    step();
    restore_mret_i = 1'b0;
    read_check(CSR_MSTATUS, 32'h0000_0088);
    check_word("mstatus_mie_o", 32'h1, {31'd0, mstatus_mie_o});
    save_cause_i = 1'b1;                                  // second trap, pc from ID
    step();
    save_cause_i = 1'b0;
    exp_mepc = pc_id_i;
    check_word("mepc_o", exp_mepc, mepc_o);
    csr_cmd(CSR_OP_WRITE, CSR_MSTATUS, 32'h0);            // mpie off before mret
    restore_mret_i = 1'b1;
    step();
    restore_mret_i = 1'b0;
    read_check(CSR_MSTATUS, 32'h0000_0080);               // mpie forced on

    // 5: counters
    rnd = $random(seed);
    k   = 3 + int'(rnd[2:0]);
    csr_peek(CSR_MCYCLE, v0);
    repeat (k - 1) step();
    csr_peek(CSR_MCYCLE, v1);
    check_word("csr_rdata_o[CSR_MCYCLE] delta", 32'(k), v1 - v0);
    csr_cmd(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'hFFFF_FFFF);
    read_check(CSR_MCOUNTINHIBIT, 32'h0000_0005);         // only bits 0 and 2 kept
    rnd = $random(seed);
    csr_cmd(CSR_OP_WRITE, CSR_MCYCLE, rnd);
    repeat (k) step();
    read_check(CSR_MCYCLE, rnd);                          // frozen while inhibited
    csr_cmd(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h0);
    csr_peek(CSR_MINSTRET, v0);
    pulses = 0;
    for (int i = 0; i < 20; i++) begin
      rnd         = $random(seed);
      instr_ret_i = rnd[0];
      if (rnd[0]) pulses++;
      step();
    end
    instr_ret_i = 1'b0;
    csr_peek(CSR_MINSTRET, v1);
    check_word("csr_rdata_o[CSR_MINSTRET] delta", 32'(pulses), v1 - v0);
    rnd = $random(seed);
    csr_cmd(CSR_OP_WRITE, CSR_MCYCLEH, rnd);
    read_check(CSR_MCYCLEH, rnd);

    // 6: illegal accesses leave state alone
    illegal_check(12'h7C0, CSR_OP_READ);
    illegal_check(12'h7C0, CSR_OP_WRITE);
    illegal_check(12'hC00, CSR_OP_WRITE);
    read_check(CSR_MSCRATCH, exp_mscratch);
    read_check(CSR_MTVAL, exp_mtval);
    read_check(CSR_MEPC, exp_mepc);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* tests/csr_chk.sv */
// CSR port checks
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_chk (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     csr_access_i,
  input logic                     illegal_csr_i,
  input logic                     irq_software_i,
  input logic                     irq_timer_i,
  input logic                     irq_external_i,
  input logic [`CSR_NUM_FAST-1:0] irq_fast_i,
  input logic                     irq_pending_i,
  input csr_pkg::irq_vec_t        mip_i
);

  // no access, no illegal flag
  idle_not_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                     !csr_access_i |-> !illegal_csr_i)
    else $error("illegal_csr_o high without an access");

  pending_is_mip_or: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                      irq_pending_i == (mip_i != '0))
    else $error("irq_pending_o does not match the OR of mip_o");

  // quiet lines give nothing pending
  quiet_not_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                      (!irq_software_i && !irq_timer_i && !irq_external_i
                                       && irq_fast_i == '0) |-> !irq_pending_i)
    else $error("irq_pending_o high with all interrupt lines low");

endmodule

bind csr_top csr_chk u_chk (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .csr_access_i   (csr_access_i),
  .illegal_csr_i  (illegal_csr_o),
  .irq_software_i (irq_software_i),
  .irq_timer_i    (irq_timer_i),
  .irq_external_i (irq_external_i),
  .irq_fast_i     (irq_fast_i),
  .irq_pending_i  (irq_pending_o),
  .mip_i          (mip_o)
);

/* rtl/csr_top.sv */
// Machine-mode CSR block
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // register access
  input  logic                     csr_access_i,
  input  csr_pkg::csr_addr_e       csr_addr_i,
  input  csr_pkg::csr_op_e         csr_op_i,
  input  logic [`CSR_XLEN-1:0]     csr_wdata_i,
  input  logic                     instr_new_i,
  output logic [`CSR_XLEN-1:0]     csr_rdata_o,
  output logic                     illegal_csr_o,
  // interrupt lines
  input  logic                     irq_software_i,
  input  logic                     irq_timer_i,
  input  logic                     irq_external_i,
  input  logic [`CSR_NUM_FAST-1:0] irq_fast_i,
  output logic                     irq_pending_o,
  output csr_pkg::irq_vec_t        mip_o,
  // trap control
  input  logic [`CSR_XLEN-1:0]     pc_if_i,
  input  logic [`CSR_XLEN-1:0]     pc_id_i,
  input  logic                     save_if_i,
  input  logic                     save_cause_i,
  input  logic                     restore_mret_i,
  input  logic [`CSR_CAUSE_W-1:0]  mcause_i,
  input  logic [`CSR_XLEN-1:0]     mtval_i,
  output logic                     mstatus_mie_o,
  output logic [`CSR_XLEN-1:0]     mepc_o,
  // counters
  input  logic                     instr_ret_i
);

  import csr_pkg::*;

  csr_wr_t      wr;
  csr_trap_rd_t trap_rd;
  csr_cnt_rd_t  cnt_rd;
  irq_vec_t     irq;

  assign irq = '{software: irq_software_i, timer: irq_timer_i,
                 external: irq_external_i, fast: irq_fast_i};

  csr_access u_access (
    .csr_access_i  (csr_access_i),
    .csr_addr_i    (csr_addr_i),
    .csr_op_i      (csr_op_i),
    .csr_wdata_i   (csr_wdata_i),
    .instr_new_i   (instr_new_i),
    .trap_rd_i     (trap_rd),
    .cnt_rd_i      (cnt_rd),
    .wr_o          (wr),
    .csr_rdata_o   (csr_rdata_o),
    .illegal_csr_o (illegal_csr_o)
  );

  csr_trap_regs u_trap (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr_i           (wr),
    .irq_i          (irq),
    .pc_if_i        (pc_if_i),
    .pc_id_i        (pc_id_i),
    .save_if_i      (save_if_i),
    .save_cause_i   (save_cause_i),
    .restore_mret_i (restore_mret_i),
    .mcause_i       (mcause_i),
    .mtval_i        (mtval_i),
    .trap_rd_o      (trap_rd),
    .irq_pending_o  (irq_pending_o),
    .mstatus_mie_o  (mstatus_mie_o),
    .mip_o          (mip_o),
    .mepc_o         (mepc_o)
  );

  csr_counters u_cnt (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_i        (wr),
    .instr_ret_i (instr_ret_i),
    .cnt_rd_o    (cnt_rd)
  );

endmodule

/* rtl/csr_counters.sv */
// Cycle and retire counters
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_counters (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  csr_pkg::csr_wr_t     wr_i,
  input  logic                 instr_ret_i,   // instr retired this cycle
  output csr_pkg::csr_cnt_rd_t cnt_rd_o
);

  logic                  cy_inh_q;   // mcountinhibit bit 0
  logic                  ir_inh_q;   // mcountinhibit bit 2
  logic [`CSR_CNT_W-1:0] mcycle_q, mcycle_d;
  logic [`CSR_CNT_W-1:0] minstret_q, minstret_d;

  // a write replaces one half, otherwise count
  function automatic logic [`CSR_CNT_W-1:0] cnt_next(
    input logic [`CSR_CNT_W-1:0] q,
    input logic                  inc,
    input logic                  we_lo,
    input logic                  we_hi,
    input logic [`CSR_XLEN-1:0]  d
  );
    logic [`CSR_CNT_W-1:0] n;
    n = q;
    if (we_lo) begin
      n[`CSR_XLEN-1:0] = d;
    end else if (we_hi) begin
      n[`CSR_CNT_W-1:`CSR_XLEN] = d;
    end else if (inc) begin
      n = q + 1'b1;
    end
    return n;
  endfunction

  assign mcycle_d = cnt_next(mcycle_q, ~cy_inh_q, wr_i.mcycle_we, wr_i.mcycleh_we,
                             wr_i.wdata);
  assign minstret_d = cnt_next(minstret_q, instr_ret_i & ~ir_inh_q, wr_i.minstret_we,
                               wr_i.minstreth_we, wr_i.wdata);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cy_inh_q   <= 1'b0;
      ir_inh_q   <= 1'b0;
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      if (wr_i.mcountinhibit_we) begin
        cy_inh_q <= wr_i.wdata[0];
        ir_inh_q <= wr_i.wdata[2];
      end
      mcycle_q   <= mcycle_d;
      minstret_q <= minstret_d;
    end
  end

  // unstored inhibit bits read as zero
  assign cnt_rd_o.mcountinhibit = {{(`CSR_XLEN-3){1'b0}}, ir_inh_q, 1'b0, cy_inh_q};
  assign cnt_rd_o.mcycle        = mcycle_q;
  assign cnt_rd_o.minstret      = minstret_q;

endmodule

/* rtl/csr_trap_regs.sv */
// Trap and interrupt registers
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_trap_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  csr_pkg::csr_wr_t        wr_i,
  input  csr_pkg::irq_vec_t       irq_i,
  input  logic [`CSR_XLEN-1:0]    pc_if_i,
  input  logic [`CSR_XLEN-1:0]    pc_id_i,
  input  logic                    save_if_i,       // save pc of IF instead of ID
  input  logic                    save_cause_i,
  input  logic                    restore_mret_i,
  input  logic [`CSR_CAUSE_W-1:0] mcause_i,
  input  logic [`CSR_XLEN-1:0]    mtval_i,
  output csr_pkg::csr_trap_rd_t   trap_rd_o,
  output logic                    irq_pending_o,
  output logic                    mstatus_mie_o,
  output csr_pkg::irq_vec_t       mip_o,
  output logic [`CSR_XLEN-1:0]    mepc_o
);

  import csr_pkg::*;

  logic                    st_mie_q, st_mie_d;
  logic                    st_mpie_q, st_mpie_d;
  irq_vec_t                mie_q, mie_d;
  logic [`CSR_XLEN-1:0]    mscratch_q, mscratch_d;
  logic [`CSR_XLEN-1:0]    mepc_q, mepc_d;
  logic [`CSR_CAUSE_W-1:0] mcause_q, mcause_d;
  logic [`CSR_XLEN-1:0]    mtval_q, mtval_d;
  logic [`CSR_XLEN-1:0]    exception_pc;
  irq_vec_t                mip;
  csr_word_u               wr_word;

  // place an interrupt set at its mie/mip bit positions
  function automatic csr_word_u irq_to_word(irq_vec_t v);
    csr_word_u w;
    w.raw          = '0;
    w.irq.software = v.software;
    w.irq.timer    = v.timer;
    w.irq.external = v.external;
    w.irq.fast     = v.fast;
    return w;
  endfunction

  assign wr_word.raw  = wr_i.wdata;
  assign exception_pc = save_if_i ? pc_if_i : pc_id_i;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    st_mie_d   = st_mie_q;
    st_mpie_d  = st_mpie_q;
    mie_d      = mie_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;

    // plain CSR writes
    if (wr_i.mstatus_we) begin
      st_mie_d  = wr_i.wdata[`CSR_MIE_BIT];
      st_mpie_d = wr_i.wdata[`CSR_MPIE_BIT];
    end
    if (wr_i.mie_we) begin
      mie_d.software = wr_word.irq.software;
      mie_d.timer    = wr_word.irq.timer;
      mie_d.external = wr_word.irq.external;
      mie_d.fast     = wr_word.irq.fast;
    end
    if (wr_i.mscratch_we) mscratch_d = wr_i.wdata;
    if (wr_i.mepc_we)     mepc_d     = {wr_i.wdata[`CSR_XLEN-1:1], 1'b0};
    if (wr_i.mcause_we) begin
      mcause_d = {wr_i.wdata[`CSR_XLEN-1], wr_i.wdata[`CSR_CAUSE_W-2:0]};
    end
    if (wr_i.mtval_we)    mtval_d    = wr_i.wdata;

    // trap controller wins over CSR writes
    if (save_cause_i) begin
      mepc_d    = exception_pc;
      mcause_d  = mcause_i;
      mtval_d   = mtval_i;
      st_mpie_d = st_mie_q;
      st_mie_d  = 1'b0;   // irqs off in handler
    end else if (restore_mret_i) begin
      st_mie_d  = st_mpie_q;
      st_mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_mie_q   <= 1'b0;
      st_mpie_q  <= 1'b0;
      mie_q      <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      st_mie_q   <= st_mie_d;
      st_mpie_q  <= st_mpie_d;
      mie_q      <= mie_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  // mip has no state, follows the lines directly
  assign mip           = irq_i & mie_q;
  assign mip_o         = mip;
  assign irq_pending_o = mip.software | mip.timer | mip.external | (|mip.fast);
  assign mstatus_mie_o = st_mie_q;
  assign mepc_o        = mepc_q;

  always_comb begin
    trap_rd_o                        = '0;
    trap_rd_o.mstatus[`CSR_MIE_BIT]  = st_mie_q;
    trap_rd_o.mstatus[`CSR_MPIE_BIT] = st_mpie_q;
    trap_rd_o.mie                    = irq_to_word(mie_q).raw;
    trap_rd_o.mip                    = irq_to_word(mip).raw;
    trap_rd_o.mscratch               = mscratch_q;
    trap_rd_o.mepc                   = mepc_q;
    trap_rd_o.mcause = {mcause_q[`CSR_CAUSE_W-1], {(`CSR_XLEN-`CSR_CAUSE_W){1'b0}},
                        mcause_q[`CSR_CAUSE_W-2:0]};
    trap_rd_o.mtval                  = mtval_q;
  end

endmodule

/* rtl/csr_access.sv */
// CSR access and decode
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_access (
  input  logic                   csr_access_i,
  input  csr_pkg::csr_addr_e     csr_addr_i,
  input  csr_pkg::csr_op_e       csr_op_i,
  input  logic [`CSR_XLEN-1:0]   csr_wdata_i,
  input  logic                   instr_new_i,   // new instr in ID
  input  csr_pkg::csr_trap_rd_t  trap_rd_i,
  input  csr_pkg::csr_cnt_rd_t   cnt_rd_i,
  output csr_pkg::csr_wr_t       wr_o,
  output logic [`CSR_XLEN-1:0]   csr_rdata_o,
  output logic                   illegal_csr_o
);

  import csr_pkg::*;

  logic [11:0]          csr_addr;
  logic                 illegal_addr;
  logic                 illegal_write;
  logic                 wreq;
  logic                 we;
  logic [`CSR_XLEN-1:0] wdata;

  assign csr_addr = csr_addr_i;

  ////////////////////
  // read mux
  ////////////////////

  always_comb begin
    csr_rdata_o  = '0;
    illegal_addr = 1'b0;
    case (csr_addr_i)
      CSR_MSTATUS:       csr_rdata_o = trap_rd_i.mstatus;
      CSR_MIE:           csr_rdata_o = trap_rd_i.mie;
      CSR_MIP:           csr_rdata_o = trap_rd_i.mip;
      CSR_MSCRATCH:      csr_rdata_o = trap_rd_i.mscratch;
      CSR_MEPC:          csr_rdata_o = trap_rd_i.mepc;
      CSR_MCAUSE:        csr_rdata_o = trap_rd_i.mcause;
      CSR_MTVAL:         csr_rdata_o = trap_rd_i.mtval;
      CSR_MCOUNTINHIBIT: csr_rdata_o = cnt_rd_i.mcountinhibit;
      CSR_MCYCLE:        csr_rdata_o = cnt_rd_i.mcycle[`CSR_XLEN-1:0];
      CSR_MCYCLEH:       csr_rdata_o = cnt_rd_i.mcycle[`CSR_CNT_W-1:`CSR_XLEN];
      CSR_MINSTRET:      csr_rdata_o = cnt_rd_i.minstret[`CSR_XLEN-1:0];
      CSR_MINSTRETH:     csr_rdata_o = cnt_rd_i.minstret[`CSR_CNT_W-1:`CSR_XLEN];
      default:           illegal_addr = 1'b1;   // unimplemented
    endcase
  end

  ////////////////////
  // operation
  ////////////////////

  always_comb begin
    wreq = 1'b1;
    case (csr_op_i)
      CSR_OP_WRITE: wdata = csr_wdata_i;
      CSR_OP_SET:   wdata = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: wdata = ~csr_wdata_i & csr_rdata_o;
      default: begin
        wdata = csr_wdata_i;   // read only, nothing written
        wreq  = 1'b0;
      end
    endcase
  end

  // top two address bits set means read-only range
  assign illegal_write = (csr_addr[11:10] == 2'b11) && wreq;
  assign illegal_csr_o = csr_access_i & (illegal_addr | illegal_write);

  // single-cycle write, only on a fresh instr
  assign we = csr_access_i & instr_new_i & wreq & ~illegal_addr & ~illegal_write;

  ////////////////////
  // write strobes
  ////////////////////

  always_comb begin
    wr_o       = '0;
    wr_o.wdata = wdata;
    case (csr_addr_i)
      CSR_MSTATUS:       wr_o.mstatus_we       = we;
      CSR_MIE:           wr_o.mie_we           = we;
      CSR_MSCRATCH:      wr_o.mscratch_we      = we;
      CSR_MEPC:          wr_o.mepc_we          = we;
      CSR_MCAUSE:        wr_o.mcause_we        = we;
      CSR_MTVAL:         wr_o.mtval_we         = we;
      CSR_MCOUNTINHIBIT: wr_o.mcountinhibit_we = we;
      CSR_MCYCLE:        wr_o.mcycle_we        = we;
      CSR_MCYCLEH:       wr_o.mcycleh_we       = we;
      CSR_MINSTRET:      wr_o.minstret_we      = we;
      CSR_MINSTRETH:     wr_o.minstreth_we     = we;
      default: ;                                       // mip writes are dropped
    endcase
  end

endmodule

/* rtl/csr_pkg.sv */
// CSR shared types
`include "csr_settings.svh"

package csr_pkg;

  // implemented machine-mode addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MIE           = 12'h304,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_OP_READ,
    CSR_OP_WRITE,
    CSR_OP_SET,
    CSR_OP_CLEAR
  } csr_op_e;

  // interrupt set, same for mie and mip
  typedef struct packed {
    logic                     software;
    logic                     timer;
    logic                     external;
    logic [`CSR_NUM_FAST-1:0] fast;
  } irq_vec_t;

  // mie/mip word layout, fields at their architectural positions
  typedef struct packed {
    logic [`CSR_XLEN-`CSR_MFI_LOW-`CSR_NUM_FAST-1:0] zero_top;
    logic [`CSR_NUM_FAST-1:0]                        fast;
    logic [`CSR_MFI_LOW-`CSR_MEI_BIT-2:0]            zero_mid2;
    logic                                            external;
    logic [`CSR_MEI_BIT-`CSR_MTI_BIT-2:0]            zero_mid1;
    logic                                            timer;
    logic [`CSR_MTI_BIT-`CSR_MSI_BIT-2:0]            zero_mid0;
    logic                                            software;
    logic [`CSR_MSI_BIT-1:0]                         zero_low;
  } csr_irq_word_t;

  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;
    csr_irq_word_t        irq;
  } csr_word_u;

  // write strobes and data, one strobe per writable register
  typedef struct packed {
    logic                 mstatus_we;
    logic                 mie_we;
    logic                 mscratch_we;
    logic                 mepc_we;
    logic                 mcause_we;
    logic                 mtval_we;
    logic                 mcountinhibit_we;
    logic                 mcycle_we;
    logic                 mcycleh_we;
    logic                 minstret_we;
    logic                 minstreth_we;
    logic [`CSR_XLEN-1:0] wdata;
  } csr_wr_t;

  typedef struct packed {
    logic [`CSR_XLEN-1:0] mstatus;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mip;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
  } csr_trap_rd_t;

  typedef struct packed {
    logic [`CSR_XLEN-1:0]  mcountinhibit;
    logic [`CSR_CNT_W-1:0] mcycle;
    logic [`CSR_CNT_W-1:0] minstret;
  } csr_cnt_rd_t;

endpackage

/* rtl/csr_settings.svh */
// CSR block settings
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// widths
`define CSR_XLEN      32
`define CSR_CNT_W     64
`define CSR_NUM_FAST  15
`define CSR_CAUSE_W   6   // irq flag plus 5-bit code

// mstatus bit positions
`define CSR_MIE_BIT   3
`define CSR_MPIE_BIT  7

// mip / mie bit positions
`define CSR_MSI_BIT   3
`define CSR_MTI_BIT   7
`define CSR_MEI_BIT   11
`define CSR_MFI_LOW   16  // lowest fast interrupt

`endif
